/* RamReadoutTop.f */
hw/ReadoutPkg.sv
hw/ChainWordIf.sv
hw/ChainRamReader.sv
hw/ReadoutMerger.sv
hw/RamReadDoneSync.sv
hw/ReadoutFramer.sv
hw/RamReadoutTop.sv
testbench/RamReadoutTb.sv

/* hw/ChainRamReader.sv */
`timescale 1ns/1ps

module ChainRamReader #(
  parameter int DataWidth = ReadoutPkg::DataWidth,
  parameter int AddrWidth = ReadoutPkg::AddrWidth
) (
  input  logic                 Clk,
  input  logic                 reset_n,
  input  logic                 Start,
  input  logic                 Enable,
  input  logic [AddrWidth-1:0] Length,
  input  logic                 LoadValid,
  input  logic [AddrWidth-1:0] LoadAddr,
  input  logic [DataWidth-1:0] LoadData,
  ChainWordIf.reader           Chain
);

  logic [DataWidth-1:0] Mem [2**AddrWidth];
  logic [AddrWidth-1:0] ReadAddr;
  logic [AddrWidth-1:0] LastAddr;
  logic                 Busy;
  logic                 Fetch;
  logic                 LastWord;

  ////////////////////////////////////////
  // Chain RAM
  ////////////////////////////////////////

  // Filled by the acquisition side through the load port
  always_ff @(posedge Clk) begin
    if (LoadValid) begin
      Mem[LoadAddr] <= LoadData;
    end
  end

  ////////////////////////////////////////
  // Read sequencer
  ////////////////////////////////////////

  // A word leaves only while the merger grants this chain
  assign Fetch    = Busy & Chain.Slot;
  assign LastWord = (ReadAddr == LastAddr);

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      Busy     <= 1'b0;
      ReadAddr <= '0;
      LastAddr <= '0;
    end else if (Start) begin
      // Zero length means nothing to read, so stay idle
      Busy     <= Enable && (Length != '0);
      ReadAddr <= '0;
      LastAddr <= Length - AddrWidth'(1);
    end else if (Fetch) begin
      ReadAddr <= ReadAddr + AddrWidth'(1);
      if (LastWord) begin
        Busy <= 1'b0;
      end
    end
  end

  // Asynchronous read, the word is on Data in its slot
  assign Chain.Valid   = Fetch;
  assign Chain.Data    = Mem[ReadAddr];
  assign Chain.OnceEnd = Fetch & LastWord;

endmodule

/* hw/ChainWordIf.sv */
`timescale 1ns/1ps

interface ChainWordIf #(
  parameter int DataWidth = ReadoutPkg::DataWidth
);

  // Read slot from the merger
  logic                 Slot;
  // Word stream from the reader
  logic                 Valid;
  logic [DataWidth-1:0] Data;
  // Last word of the chain, same cycle as its Valid
  logic                 OnceEnd;

  modport reader (
    input  Slot,
    output Valid,
    output Data,
    output OnceEnd
  );

  modport merger (
    output Slot,
    input  Valid,
    input  Data
  );

  modport doneSync (
    input  OnceEnd
  );

endinterface

/* hw/RamReadDoneSync.sv */
`timescale 1ns/1ps

module RamReadDoneSync #(
  parameter int ChainCount = ReadoutPkg::ChainCount,
  parameter int DoneHold   = ReadoutPkg::DoneHoldDefault
) (
  input  logic                  Clk,
  input  logic                  reset_n,
  ChainWordIf.doneSync          Chains [ChainCount],
  input  ReadoutPkg::chainMaskT EnableMask,
  output logic                  RamReadoutDone
);

  localparam int HoldWidth = $clog2(DoneHold + 1);

  logic [ChainCount-1:0] EndVec;
  logic [ChainCount-1:0] Hit;
  logic                  AllHit;
  logic [HoldWidth-1:0]  HoldCount;

  for (genvar i = 0; i < ChainCount; i++) begin : gEnd
    assign EndVec[i] = Chains[i].OnceEnd;
  end

  ////////////////////////////////////////
  // End hits and compare
  ////////////////////////////////////////

  // Hits collect end strobes and are wiped while done is held
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      Hit    <= '0;
      AllHit <= 1'b0;
    end else begin
      Hit    <= (Hit | EndVec) & {ChainCount{~RamReadoutDone}};
      // An empty hit set never counts as a finished run
      AllHit <= (Hit == EnableMask[ChainCount-1:0]) && (|Hit) && !RamReadoutDone;
    end
  end

  ////////////////////////////////////////
  // Done hold
  ////////////////////////////////////////

  // HoldCount runs 1..DoneHold while the level is up
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      RamReadoutDone <= 1'b0;
      HoldCount      <= '0;
    end else if (!RamReadoutDone) begin
      if (AllHit) begin
        RamReadoutDone <= 1'b1;
        HoldCount      <= HoldWidth'(1);
      end
    end else if (HoldCount == HoldWidth'(DoneHold)) begin
      RamReadoutDone <= 1'b0;
      HoldCount      <= '0;
    end else begin
      HoldCount <= HoldCount + HoldWidth'(1);
    end
  end

endmodule

/* hw/RamReadoutTop.sv */
`timescale 1ns/1ps

module RamReadoutTop #(
  parameter int ChainCount = ReadoutPkg::ChainCount,
  parameter int DataWidth  = ReadoutPkg::DataWidth,
  parameter int AddrWidth  = ReadoutPkg::AddrWidth,
  parameter int DoneHold   = ReadoutPkg::DoneHoldDefault
) (
  input  logic                  Clk,
  input  logic                  reset_n,
  input  logic                  Start,
  input  ReadoutPkg::chainMaskT ChainEnable,
  input  logic [AddrWidth-1:0]  Length,
  input  logic                  LoadValid,
  input  ReadoutPkg::chainIdxT  LoadChain,
  input  logic [AddrWidth-1:0]  LoadAddr,
  input  logic [DataWidth-1:0]  LoadData,
  output logic                  OutValid,
  output logic [DataWidth-1:0]  OutData,
  output ReadoutPkg::chainIdxT  OutChain,
  output logic                  OutTrailer,
  output logic                  RamReadoutDone
);
  import ReadoutPkg::*;

  chainMaskT            EnableMask;
  logic                 MergedValid;
  logic [DataWidth-1:0] MergedData;
  chainIdxT             MergedChain;

  ChainWordIf #(.DataWidth(DataWidth)) Chains [ChainCount] ();

  // Mask of the run in progress, for the done compare
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      EnableMask <= '0;
    end else if (Start) begin
      EnableMask <= ChainEnable;
    end
  end

  ////////////////////////////////////////
  // Per-chain readers
  ////////////////////////////////////////

  for (genvar i = 0; i < ChainCount; i++) begin : gReader
    ChainRamReader #(
      .DataWidth (DataWidth),
      .AddrWidth (AddrWidth)
    ) uReader (
      .Clk       (Clk),
      .reset_n   (reset_n),
      .Start     (Start),
      .Enable    (ChainEnable[i]),
      .Length    (Length),
      .LoadValid (LoadValid && (LoadChain == chainIdxT'(i))),
      .LoadAddr  (LoadAddr),
      .LoadData  (LoadData),
      .Chain     (Chains[i])
    );
  end

  ////////////////////////////////////////
  // Merge, done and framing
  ////////////////////////////////////////

  ReadoutMerger #(
    .ChainCount (ChainCount),
    .DataWidth  (DataWidth)
  ) uMerger (
    .Clk         (Clk),
    .reset_n     (reset_n),
    .Chains      (Chains),
    .MergedValid (MergedValid),
    .MergedData  (MergedData),
    .MergedChain (MergedChain)
  );

  RamReadDoneSync #(
    .ChainCount (ChainCount),
    .DoneHold   (DoneHold)
  ) uDoneSync (
    .Clk            (Clk),
    .reset_n        (reset_n),
    .Chains         (Chains),
    .EnableMask     (EnableMask),
    .RamReadoutDone (RamReadoutDone)
  );

  ReadoutFramer #(
    .DataWidth (DataWidth)
  ) uFramer (
    .Clk            (Clk),
    .reset_n        (reset_n),
    .Start          (Start),
    .MergedValid    (MergedValid),
    .MergedData     (MergedData),
    .MergedChain    (MergedChain),
    .RamReadoutDone (RamReadoutDone),
    .OutValid       (OutValid),
    .OutData        (OutData),
    .OutChain       (OutChain),
    .OutTrailer     (OutTrailer)
  );

endmodule

/* hw/ReadoutFramer.sv */
`timescale 1ns/1ps

module ReadoutFramer #(
  parameter int DataWidth = ReadoutPkg::DataWidth
) (
  input  logic                 Clk,
  input  logic                 reset_n,
  input  logic                 Start,
  input  logic                 MergedValid,
  input  logic [DataWidth-1:0] MergedData,
  input  ReadoutPkg::chainIdxT MergedChain,
  input  logic                 RamReadoutDone,
  output logic                 OutValid,
  output logic [DataWidth-1:0] OutData,
  output ReadoutPkg::chainIdxT OutChain,
  output logic                 OutTrailer
);

  logic                 WordValid;
  logic [DataWidth-1:0] WordData;
  logic [DataWidth-1:0] WordCount;
  logic                 DoneLast;

  // Output stage and word count
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      WordValid <= 1'b0;
      WordCount <= '0;
      DoneLast  <= 1'b0;
    end else begin
      WordValid <= MergedValid;
      DoneLast  <= RamReadoutDone;
      if (Start) begin
        WordCount <= '0;
      end else if (MergedValid) begin
        WordCount <= WordCount + DataWidth'(1);
      end
    end
  end

  always_ff @(posedge Clk) begin
    WordData <= MergedData;
    OutChain <= MergedChain;
  end

  // Trailer on the rising edge of done, the data stage is empty by then
  assign OutTrailer = RamReadoutDone & ~DoneLast;
  assign OutValid   = WordValid | OutTrailer;
  assign OutData    = OutTrailer ? WordCount : WordData;

endmodule

/* hw/ReadoutMerger.sv */
`timescale 1ns/1ps

module ReadoutMerger #(
  parameter int ChainCount = ReadoutPkg::ChainCount,
  parameter int DataWidth  = ReadoutPkg::DataWidth
) (
  input  logic                 Clk,
  input  logic                 reset_n,
  ChainWordIf.merger           Chains [ChainCount],
  output logic                 MergedValid,
  output logic [DataWidth-1:0] MergedData,
  output ReadoutPkg::chainIdxT MergedChain
);
  import ReadoutPkg::*;

  chainIdxT              SlotIdx;
  logic [ChainCount-1:0] ValidVec;
  logic [DataWidth-1:0]  DataVec [ChainCount];

  // One slot per cycle, so chains never collide
  for (genvar i = 0; i < ChainCount; i++) begin : gSlot
    assign Chains[i].Slot = (SlotIdx == chainIdxT'(i));
    assign ValidVec[i]    = Chains[i].Valid;
    assign DataVec[i]     = Chains[i].Data;
  end

  // Free-running slot rotation
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      SlotIdx     <= '0;
      MergedValid <= 1'b0;
    end else begin
      if (SlotIdx == chainIdxT'(ChainCount - 1)) begin
        SlotIdx <= '0;
      end else begin
        SlotIdx <= SlotIdx + chainIdxT'(1);
      end
      MergedValid <= ValidVec[SlotIdx];
    end
  end

  // Word of the slotted chain, tagged with its index
  always_ff @(posedge Clk) begin
    MergedData  <= DataVec[SlotIdx];
    MergedChain <= SlotIdx;
  end

endmodule

/* hw/ReadoutPkg.sv */
package ReadoutPkg;

  ////////////////////////////////////////
  // Board geometry
  ////////////////////////////////////////

  // ASIC chains served by one board
  parameter int ChainCount = 4;

  // One RAM word as read back from a chain
  parameter int DataWidth = 16;

  // 64 words per chain RAM
  parameter int AddrWidth = 6;

  ////////////////////////////////////////
  // Chain bookkeeping types
  ////////////////////////////////////////

  // Chain index, also the tag on merged words
  typedef logic [1:0] chainIdxT;

  // One bit per chain, for the enable mask and the end hits
  typedef logic [ChainCount-1:0] chainMaskT;

  ////////////////////////////////////////
  // Done level
  ////////////////////////////////////////

  // Cycles that RamReadoutDone stays high
  parameter int DoneHoldDefault = 11;

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the readout testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module RamReadoutTb \
  -f RamReadoutTop.f -o RamReadoutSim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/RamReadoutSim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q -x -F ">>> PASS"; then
  exit 0
fi
echo "Pass message not found"
exit 1

/* testbench/RamReadoutTb.sv */
`timescale 1ns/1ps

module RamReadoutTb;
  import ReadoutPkg::*;

  localparam int DoneHold = DoneHoldDefault;
  localparam int Depth    = 2**AddrWidth;
  localparam int Timeout  = 2000;

  logic                 Clk;
  logic                 reset_n;
  logic                 Start;
  chainMaskT            ChainEnable;
  logic [AddrWidth-1:0] Length;
  logic                 LoadValid;
  chainIdxT             LoadChain;
  logic [AddrWidth-1:0] LoadAddr;
  logic [DataWidth-1:0] LoadData;
  logic                 OutValid;
  logic [DataWidth-1:0] OutData;
  chainIdxT             OutChain;
  logic                 OutTrailer;
  logic                 RamReadoutDone;

  // Reference copy of the chain RAMs
  logic [DataWidth-1:0] RamCopy [ChainCount][Depth];
  integer               seed;

  // Scoreboard of the run in progress
  int        NextAddr [ChainCount];
  chainMaskT RunMask;
  int        RunLength;
  int        RunTotal;
  int        TrailerCount = 0;
  int        HoldRun = 0;
  logic      DoneSeen = 1'b0;
  logic      Started = 1'b0;

  RamReadoutTop #(
    .DoneHold (DoneHold)
  ) DUT (
    .Clk (Clk), .reset_n (reset_n), .Start (Start),
    .ChainEnable (ChainEnable), .Length (Length),
    .LoadValid (LoadValid), .LoadChain (LoadChain),
    .LoadAddr (LoadAddr), .LoadData (LoadData),
    .OutValid (OutValid), .OutData (OutData), .OutChain (OutChain),
    .OutTrailer (OutTrailer), .RamReadoutDone (RamReadoutDone)
  );

  always #4 Clk = ~Clk;

  task automatic stopOnError(input string line);
    $display(">>> FAIL");
    $display("%s", line);
    $fatal(1, "stopped at first error");
  endtask

  task automatic reportMismatch(input string name, input logic [31:0] expVal,
                                input logic [31:0] gotVal);
    stopOnError($sformatf("mismatch %s expected 0x%h got 0x%h", name, expVal, gotVal));
  endtask

  ////////////////////////////////////////
  // Temporal checks
  ////////////////////////////////////////

  quietBeforeStart: assert property (@(posedge Clk)
      !Started |-> (!OutValid && !OutTrailer && !RamReadoutDone))
    else reportMismatch("OutValid,OutTrailer,RamReadoutDone", 32'h0,
      {29'b0, $sampled(OutValid), $sampled(OutTrailer), $sampled(RamReadoutDone)});

  // Trailer exactly in the first done cycle
  trailerOnDoneRise: assert property (@(posedge Clk) disable iff (!reset_n)
      OutTrailer == $rose(RamReadoutDone))
    else reportMismatch("OutTrailer", {31'b0, ~$sampled(OutTrailer)},
      {31'b0, $sampled(OutTrailer)});

  trailerIsValid: assert property (@(posedge Clk) OutTrailer |-> OutValid)
    else reportMismatch("OutValid", 32'h1, 32'h0);

  ////////////////////////////////////////
  // Scoreboard, sampled mid-cycle
  ////////////////////////////////////////

  always @(negedge Clk) begin
    if (Start) begin
      Started      = 1'b1;
      RunMask      = ChainEnable;
      RunLength    = int'(Length);
      RunTotal     = $countones(ChainEnable) * int'(Length);
      TrailerCount = 0;
      for (int c = 0; c < ChainCount; c++) begin
        NextAddr[c] = 0;
      end
    end
    if (OutValid && !OutTrailer) begin
      assert (RunMask[OutChain])
        else stopOnError($sformatf("word from disabled chain %0d", OutChain));
      assert (NextAddr[OutChain] < RunLength)
        else stopOnError($sformatf("more than Length words from chain %0d", OutChain));
      assert (OutData == RamCopy[OutChain][NextAddr[OutChain]])
        else reportMismatch($sformatf("OutData chain %0d", OutChain),
          32'(RamCopy[OutChain][NextAddr[OutChain]]), 32'(OutData));
      assert (!RamReadoutDone) else stopOnError("data word while RamReadoutDone is high");
      NextAddr[OutChain] = NextAddr[OutChain] + 1;
    end
    if (OutTrailer) begin
      assert (OutData == DataWidth'(RunTotal))
        else reportMismatch("OutData trailer", RunTotal, 32'(OutData));
      TrailerCount = TrailerCount + 1;
    end
    if (RamReadoutDone) begin
      HoldRun = HoldRun + 1;
    end else if (DoneSeen) begin
      // Done has just fallen, close the run
      assert (HoldRun == DoneHold) else reportMismatch("RamReadoutDone hold", DoneHold, HoldRun);
      assert (TrailerCount == 1) else reportMismatch("trailer count", 1, TrailerCount);
      for (int c = 0; c < ChainCount; c++) begin
        assert (NextAddr[c] == (RunMask[c] ? RunLength : 0))
          else reportMismatch($sformatf("word count chain %0d", c),
            RunMask[c] ? RunLength : 0, NextAddr[c]);
      end
      HoldRun = 0;
    end
    DoneSeen = RamReadoutDone;
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic loadRams();
    logic [DataWidth-1:0] word;
    for (int c = 0; c < ChainCount; c++) begin
      for (int a = 0; a < Depth; a++) begin
        word = DataWidth'($random(seed));
        RamCopy[c][a] = word;
        @(posedge Clk);
        LoadValid <= 1'b1;
        LoadChain <= chainIdxT'(c);
        LoadAddr  <= AddrWidth'(a);
        LoadData  <= word;
      end
    end
    @(posedge Clk);
    LoadValid <= 1'b0;
  endtask

  // One start, then wait for done to rise and fall
  task automatic runReadout(input chainMaskT mask, input int len);
    int waitCycles;
    @(posedge Clk);
    Start       <= 1'b1;
    ChainEnable <= mask;
    Length      <= AddrWidth'(len);
    @(posedge Clk);
    Start <= 1'b0;
    waitCycles = 0;
    while (!RamReadoutDone) begin
      @(negedge Clk);
      waitCycles = waitCycles + 1;
      if (waitCycles > Timeout) begin
        stopOnError("timeout waiting for RamReadoutDone to rise");
      end
    end
    waitCycles = 0;
    while (RamReadoutDone) begin
      @(negedge Clk);
      waitCycles = waitCycles + 1;
      if (waitCycles > Timeout) begin
        stopOnError("timeout waiting for RamReadoutDone to fall");
      end
    end
  endtask

  initial begin
    Clk         = 1'b0;
    reset_n     = 1'b0;
    Start       = 1'b0;
    ChainEnable = '0;
    Length      = '0;
    LoadValid   = 1'b0;
    LoadChain   = '0;
    LoadAddr    = '0;
    LoadData    = '0;
    seed        = 58;
    repeat (10) @(posedge Clk);
    reset_n <= 1'b1;
    loadRams();
    // Idle stretch before the first start
    repeat (20) @(posedge Clk);
    runReadout(4'b1111, 12);
    runReadout(4'b0101, 7);
    runReadout(4'b0110, 1);
    runReadout(4'b1000, 20);
    runReadout(4'b1111, 63);
    repeat (5) @(posedge Clk);
    $display(">>> PASS");
    $finish;
  end

endmodule
